/* verilog/readout_settings.svh */
`ifndef READOUT_SETTINGS_SVH
`define READOUT_SETTINGS_SVH

// Channel and word geometry
`define NUM_CHANNELS   8
`define RX_DATA_W      16         // Raw word from one receiver
`define WORD_W         32         // Readout word, bus read width

// Bus side
`define BUS_ADDR_W     8
`define BUS_WDATA_W    8

// Buffer depths, powers of two
`define RX_FIFO_DEPTH  4
`define OUT_FIFO_DEPTH 16

// Register map
`define ADDR_CH_ENABLE 8'h00      // Channel enable mask
`define ADDR_TRIG_CTRL 8'h01      // Bit 0 trigger enable
`define ADDR_STATUS    8'h02      // Count and overflow flags
`define ADDR_DATA      8'h10      // Output FIFO data port

`endif

/* verilog/readout_pkg.sv */
`include "readout_settings.svh"

package readout_pkg;

    ////////////////////
    // Plain vectors
    ////////////////////
    typedef logic [`RX_DATA_W-1:0]                  rx_data_t;
    typedef logic [`WORD_W-1:0]                     word_t;
    typedef logic [`BUS_ADDR_W-1:0]                 bus_addr_t;
    typedef logic [`NUM_CHANNELS-1:0]               ch_mask_t;     // One bit per channel
    typedef logic [$clog2(`OUT_FIFO_DEPTH+1)-1:0]   fifo_count_t;  // 0 .. depth
    typedef logic [3:0]                             src_id_t;

    ////////////////////
    // Bundles
    ////////////////////

    // Bus master request, strobes last one cycle
    typedef struct packed {
        logic                      wr;
        logic                      rd;
        bus_addr_t                 addr;
        logic [`BUS_WDATA_W-1:0]   wdata;
    } bus_req_t;

    // What a source offers to the arbiter
    typedef struct packed {
        logic  avail;       // Head word valid
        word_t word;
    } src_word_t;

endpackage

/* verilog/readout_regs.sv */
`timescale 1ns/1ps
`include "readout_settings.svh"

module readout_regs
    import readout_pkg::*;
(
    input  logic        bus_clk,
    input  logic        arst_n,
    input  bus_req_t    bus_req,
    output word_t       bus_rdata,
    output ch_mask_t    ch_enable,
    output logic        trig_enable,
    input  ch_mask_t    ch_overflow,
    input  word_t       out_word,
    input  fifo_count_t out_count,
    output logic        out_pop
);

    logic  fifo_has_data;
    logic  data_rd;
    word_t rd_mux;

    assign fifo_has_data = (out_count != '0);
    assign data_rd       = bus_req.rd && (bus_req.addr == `ADDR_DATA);

    // Pop together with the read, head is captured on the same edge
    assign out_pop = data_rd && fifo_has_data;

    ////////////////////
    // Write decode
    ////////////////////
    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            ch_enable   <= '0;
            trig_enable <= 1'b0;
        end else if (bus_req.wr) begin
            case (bus_req.addr)
                `ADDR_CH_ENABLE: ch_enable   <= bus_req.wdata;
                `ADDR_TRIG_CTRL: trig_enable <= bus_req.wdata[0];
                default: ;                  // Writes elsewhere ignored
            endcase
        end
    end

    ////////////////////
    // Read mux
    ////////////////////
    always_comb begin
        case (bus_req.addr)
            `ADDR_CH_ENABLE: rd_mux = word_t'(ch_enable);
            `ADDR_TRIG_CTRL: rd_mux = word_t'(trig_enable);
            // Overflow flags in 15:8, occupancy in 4:0
            `ADDR_STATUS:    rd_mux = word_t'({ch_overflow, 3'b000, out_count});
            `ADDR_DATA:      rd_mux = fifo_has_data ? out_word : '0;  // Empty reads zero
            default:         rd_mux = '0;
        endcase
    end

    // Read data lands one cycle after rd and holds until the next read
    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            bus_rdata <= '0;
        end else if (bus_req.rd) begin
            bus_rdata <= rd_mux;
        end
    end

    // A bus pop must take a word out, buffer never grows across it
    a_pop_drains: assert property (
        @(posedge bus_clk) disable iff (!arst_n) out_pop |=> out_count <= $past(out_count)
    );

endmodule

/* verilog/rx_channel.sv */
`timescale 1ns/1ps
`include "readout_settings.svh"

module rx_channel
    import readout_pkg::*;
#(
    parameter int CHANNEL_ID = 0
) (
    input  logic      bus_clk,
    input  logic      arst_n,
    input  logic      enable,
    input  logic      rx_valid,
    input  rx_data_t  rx_data,
    input  logic      grant,
    output src_word_t src,
    output logic      overflow
);

    localparam int DEPTH = `RX_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam src_id_t SRC_ID = src_id_t'(CHANNEL_ID + 1);   // Id 0 is left to the trigger

    rx_data_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             arrive;
    logic             full;
    logic             push;

    assign arrive = enable && rx_valid;
    assign full   = (count == CNT_W'(DEPTH));
    assign push   = arrive && !full;          // Full means the word is lost

    ////////////////////
    // Channel FIFO
    ////////////////////
    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (grant)
                rd_ptr <= rd_ptr + 1'b1;       // Grant pops the head
            if (push && !grant)
                count <= count + 1'b1;
            else if (!push && grant)
                count <= count - 1'b1;
            if (arrive && full)
                overflow <= 1'b1;              // Sticky until reset
        end
    end

    always_ff @(posedge bus_clk) begin
        if (push)
            mem[wr_ptr] <= rx_data;
    end

    // Head word falls through, tagged with the channel id
    assign src.avail = (count != '0);
    assign src.word  = word_t'({SRC_ID, 8'h00, mem[rd_ptr]});

    // Arbiter must only pick this channel while it has a word
    a_grant_avail: assert property (
        @(posedge bus_clk) disable iff (!arst_n) grant |-> src.avail
    );

endmodule

/* verilog/trigger_unit.sv */
`timescale 1ns/1ps
`include "readout_settings.svh"

module trigger_unit
    import readout_pkg::*;
(
    input  logic      bus_clk,
    input  logic      arst_n,
    input  logic      enable,
    input  logic      trigger_in,
    input  logic      veto,
    input  logic      grant,
    output src_word_t src,
    output logic      busy
);

    logic                trig_q;        // Previous trigger level
    logic                rise;
    logic                accept;
    logic                pending;       // One trigger word waiting
    logic [`WORD_W-2:0]  trig_cnt;      // Next trigger number
    logic [`WORD_W-2:0]  trig_num;      // Number of the waiting word

    ////////////////////
    // Edge detect and accept
    ////////////////////
    assign rise = trigger_in && !trig_q;

    // Refused edges leave counter and state alone
    assign accept = rise && enable && !pending && !veto;

    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            trig_q   <= 1'b0;
            pending  <= 1'b0;
            trig_cnt <= 1;                 // First trigger is number one
        end else begin
            trig_q <= trigger_in;
            if (accept) begin
                pending  <= 1'b1;
                trig_cnt <= trig_cnt + 1'b1;
            end else if (grant) begin
                pending <= 1'b0;           // Word handed to the arbiter
            end
        end
    end

    // Snapshot of the counter for the waiting word
    always_ff @(posedge bus_clk) begin
        if (accept)
            trig_num <= trig_cnt;
    end

    ////////////////////
    // Outputs
    ////////////////////
    assign busy      = pending;            // High from accept until grant
    assign src.avail = pending;
    assign src.word  = {1'b1, trig_num};   // Bit 31 marks a trigger word

endmodule

/* verilog/rr_arbiter.sv */
`timescale 1ns/1ps
`include "readout_settings.svh"

module rr_arbiter
    import readout_pkg::*;
(
    input  logic                         bus_clk,
    input  logic                         arst_n,
    input  src_word_t [`NUM_CHANNELS:0]  srcs,      // Index 0 trigger, k+1 channel k
    input  logic                         full,
    output logic [`NUM_CHANNELS:0]       grants,
    output logic                         wr,
    output word_t                        wr_word
);

    localparam int NUM_SRC = `NUM_CHANNELS + 1;
    localparam int IDX_W   = $clog2(NUM_SRC);

    logic [IDX_W-1:0] start_idx;   // Search origin, one past last grant
    logic [IDX_W-1:0] win_idx;
    logic             win_valid;
    logic             grant_any;

    ////////////////////
    // Round-robin search
    ////////////////////
    always_comb begin
        int cand;
        win_valid = 1'b0;
        win_idx   = '0;
        for (int i = 0; i < NUM_SRC; i++) begin
            cand = (int'(start_idx) + i) % NUM_SRC;    // Upward with wrap
            if (!win_valid && srcs[cand].avail) begin
                win_valid = 1'b1;
                win_idx   = IDX_W'(cand);
            end
        end
    end

    assign grant_any = win_valid && !full;                 // Full output stalls everyone
    assign grants    = grant_any ? (NUM_SRC'(1) << win_idx) : '0;

    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            start_idx <= '0;
            wr        <= 1'b0;
        end else begin
            wr <= grant_any;                               // Write one cycle after grant
            if (grant_any)
                start_idx <= (win_idx == IDX_W'(NUM_SRC - 1)) ? '0 : win_idx + 1'b1;
        end
    end

    // Winning word registered for the FIFO write
    always_ff @(posedge bus_clk) begin
        if (grant_any)
            wr_word <= srcs[win_idx].word;
    end

endmodule

/* verilog/out_fifo.sv */
`timescale 1ns/1ps
`include "readout_settings.svh"

module out_fifo
    import readout_pkg::*;
(
    input  logic        bus_clk,
    input  logic        arst_n,
    input  logic        wr,
    input  word_t       wr_word,
    input  logic        pop,
    output word_t       head,
    output fifo_count_t count,
    output logic        full
);

    localparam int DEPTH = `OUT_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    word_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             push;
    logic             pull;

    assign push = wr && (count != fifo_count_t'(DEPTH));
    assign pull = pop && (count != '0);

    // Counts the write already in flight from the arbiter's last grant
    assign full = (count == fifo_count_t'(DEPTH)) ||
                  (wr && (count == fifo_count_t'(DEPTH - 1)));

    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pull)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && !pull)
                count <= count + 1'b1;
            else if (!push && pull)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge bus_clk) begin
        if (push)
            mem[wr_ptr] <= wr_word;
    end

    assign head = mem[rd_ptr];      // Valid the cycle after the write

    // Grant gating upstream must keep writes off a full buffer
    a_no_wr_full: assert property (
        @(posedge bus_clk) disable iff (!arst_n) wr |-> count != fifo_count_t'(DEPTH)
    );

endmodule

/* verilog/readout_top.sv */
`timescale 1ns/1ps
`include "readout_settings.svh"

module readout_top
    import readout_pkg::*;
(
    input  logic                           bus_clk,
    input  logic                           arst_n,
    input  bus_req_t                       bus_req,
    output word_t                          bus_rdata,
    input  ch_mask_t                       rx_valid,
    input  rx_data_t [`NUM_CHANNELS-1:0]   rx_data,
    input  logic                           trigger_in,
    output logic                           busy
);

    ch_mask_t                      ch_enable;
    ch_mask_t                      ch_overflow;
    logic                          trig_enable;
    word_t                         out_word;
    fifo_count_t                   out_count;
    logic                          out_pop;
    logic                          out_full;
    src_word_t [`NUM_CHANNELS:0]   srcs;        // Slot 0 trigger, then channels
    logic [`NUM_CHANNELS:0]        grants;
    logic                          fifo_wr;
    word_t                         fifo_wr_word;

    readout_regs i_regs (
        .bus_clk     (bus_clk),
        .arst_n      (arst_n),
        .bus_req     (bus_req),
        .bus_rdata   (bus_rdata),
        .ch_enable   (ch_enable),
        .trig_enable (trig_enable),
        .ch_overflow (ch_overflow),
        .out_word    (out_word),
        .out_count   (out_count),
        .out_pop     (out_pop)
    );

    ////////////////////
    // Receiver channels
    ////////////////////
    for (genvar k = 0; k < `NUM_CHANNELS; k++) begin : g_ch
        rx_channel #(
            .CHANNEL_ID (k)
        ) i_rx (
            .bus_clk  (bus_clk),
            .arst_n   (arst_n),
            .enable   (ch_enable[k]),
            .rx_valid (rx_valid[k]),
            .rx_data  (rx_data[k]),
            .grant    (grants[k+1]),
            .src      (srcs[k+1]),
            .overflow (ch_overflow[k])
        );
    end

    trigger_unit i_trig (
        .bus_clk    (bus_clk),
        .arst_n     (arst_n),
        .enable     (trig_enable),
        .trigger_in (trigger_in),
        .veto       (out_full),        // No triggers while output buffer full
        .grant      (grants[0]),
        .src        (srcs[0]),
        .busy       (busy)
    );

    rr_arbiter i_arb (
        .bus_clk (bus_clk),
        .arst_n  (arst_n),
        .srcs    (srcs),
        .full    (out_full),
        .grants  (grants),
        .wr      (fifo_wr),
        .wr_word (fifo_wr_word)
    );

    out_fifo i_out_fifo (
        .bus_clk (bus_clk),
        .arst_n  (arst_n),
        .wr      (fifo_wr),
        .wr_word (fifo_wr_word),
        .pop     (out_pop),
        .head    (out_word),
        .count   (out_count),
        .full    (out_full)
    );

endmodule

/* tests/tb_readout.sv */
`timescale 1ns/1ps
`include "readout_settings.svh"

module tb_readout
    import readout_pkg::*;
();

    typedef enum logic [2:0] {OP_WR, OP_RD, OP_PUSH, OP_TRIG, OP_DATA, OP_WAIT, OP_END} op_e;

    // One stimulus row, field use depends on op
    typedef struct packed {
        op_e         op;
        logic [7:0]  a;        // Address, channel mask, data kind or test index
        word_t       b;        // Write data, expected value, channel, number or cycles
        logic        c;        // Poll flag, word arrives, or expected busy
    } row_t;

    localparam logic [7:0] KIND_ZERO = 8'd0;    // Empty port reads zero
    localparam logic [7:0] KIND_CH   = 8'd1;
    localparam logic [7:0] KIND_TRIG = 8'd2;

    logic                          bus_clk;
    logic                          arst_n;
    bus_req_t                      bus_req;
    word_t                         bus_rdata;
    ch_mask_t                      rx_valid;
    rx_data_t [`NUM_CHANNELS-1:0]  rx_data;
    logic                          trigger_in;
    logic                          busy;

    row_t        rows [$];
    word_t       exp_q [`NUM_CHANNELS][$];     // Expected words per channel, arrival order
    logic [15:0] lfsr = 16'd10;                // Seed
    int          errors = 0;
    int          cycles = 0;
    int          cycle_limit = 0;
    string       test_names [6] = '{"register readback", "all channels in order",
                                    "single word", "disabled channel",
                                    "trigger words", "back-pressure"};

    readout_top i_dut (
        .bus_clk    (bus_clk),
        .arst_n     (arst_n),
        .bus_req    (bus_req),
        .bus_rdata  (bus_rdata),
        .rx_valid   (rx_valid),
        .rx_data    (rx_data),
        .trigger_in (trigger_in),
        .busy       (busy)
    );

    always #10 bus_clk = ~bus_clk;             // 20 ns period

    // Run limit, 40 cycles per row
    always @(posedge bus_clk) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    ////////////////////
    // Helpers
    ////////////////////
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);    // Galois, taps 16,14,13,11
    endfunction

    function automatic rx_data_t random_payload();
        rx_data_t p;
        p = '0;
        for (int i = 0; i < `RX_DATA_W; i++) begin
            p    = {p[`RX_DATA_W-2:0], lfsr[0]};           // One step per bit
            lfsr = lfsr_next(lfsr);
        end
        return p;
    endfunction

    function automatic void add_row(op_e op, logic [7:0] a, word_t b, logic c);
        rows.push_back('{op: op, a: a, b: b, c: c});
    endfunction

    task automatic check_word(input string what, input word_t got, input word_t exp);
        assert (got == exp) else begin
            $display("[ERROR] %0t ns: %s returned %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic step();
        @(posedge bus_clk);
        #2;                                    // Inputs change 2 ns after the edge
    endtask

    task automatic bus_write(input bus_addr_t addr, input logic [`BUS_WDATA_W-1:0] data);
        bus_req.wr    = 1'b1;
        bus_req.addr  = addr;
        bus_req.wdata = data;
        step();
        bus_req = '0;
    endtask

    task automatic bus_read(input bus_addr_t addr, output word_t data);
        bus_req.rd   = 1'b1;
        bus_req.addr = addr;
        @(posedge bus_clk);
        #1;
        data = bus_rdata;                      // Registered on the rd edge
        #1;
        bus_req = '0;
    endtask

    task automatic reg_read(input bus_addr_t addr, input word_t exp, input logic poll);
        word_t got;
        bus_read(addr, got);
        while (poll && got != exp)
            bus_read(addr, got);               // Timeout ends a wait that never matches
        check_word("register read", got, exp);
    endtask

    task automatic push_words(input ch_mask_t mask, input logic arrive);
        word_t w;
        for (int k = 0; k < `NUM_CHANNELS; k++) begin
            if (mask[k]) begin
                rx_data[k] = random_payload();
                if (arrive) begin
                    w          = '0;
                    w[27:24]   = src_id_t'(k + 1);   // Channel k carries id k+1
                    w[15:0]    = rx_data[k];
                    exp_q[k].push_back(w);
                end
            end
        end
        rx_valid = mask;
        step();
        rx_valid = '0;
    endtask

    task automatic pulse_trigger(input logic exp_busy);
        trigger_in = 1'b1;
        @(posedge bus_clk);
        #1;
        assert (busy == exp_busy) else begin
            $display("[ERROR] %0t ns: busy is %b, expected %b", $time, busy, exp_busy);
            errors++;
        end
        #1;
        trigger_in = 1'b0;
    endtask

    task automatic read_data(input logic [7:0] kind, input word_t arg);
        word_t st;
        word_t got;
        word_t exp;
        exp = '0;
        st  = '0;
        if (kind != KIND_ZERO) begin
            while (st[4:0] == 5'd0)
                bus_read(`ADDR_STATUS, st);    // Wait for a readable word
        end
        if (kind == KIND_CH) begin
            if (exp_q[arg[2:0]].size() == 0) begin
                $display("No expected word left for channel %0d", arg[2:0]);
                errors++;
            end else begin
                exp = exp_q[arg[2:0]].pop_front();
            end
        end else if (kind == KIND_TRIG) begin
            exp = {1'b1, arg[30:0]};           // Bit 31 marks a trigger word
        end
        bus_read(`ADDR_DATA, got);
        check_word("data port", got, exp);
    endtask

    ////////////////////
    // Stimulus table
    ////////////////////
    task automatic build_rows();
        add_row(OP_WR, `ADDR_CH_ENABLE, 32'hA5, 1'b0);
        add_row(OP_RD, `ADDR_CH_ENABLE, 32'hA5, 1'b0);
        add_row(OP_WR, `ADDR_TRIG_CTRL, 32'h1, 1'b0);
        add_row(OP_RD, `ADDR_TRIG_CTRL, 32'h1, 1'b0);
        add_row(OP_WR, `ADDR_CH_ENABLE, 32'hFF, 1'b0);
        add_row(OP_RD, `ADDR_CH_ENABLE, 32'hFF, 1'b0);
        add_row(OP_END, 8'd0, '0, 1'b0);
        // Search from index 0 after reset
        add_row(OP_PUSH, 8'hFF, '0, 1'b1);
        for (int k = 0; k < `NUM_CHANNELS; k++)
            add_row(OP_DATA, KIND_CH, word_t'(k), 1'b0);
        add_row(OP_END, 8'd1, '0, 1'b0);
        add_row(OP_PUSH, 8'h08, '0, 1'b1);
        add_row(OP_DATA, KIND_CH, 32'd3, 1'b0);
        add_row(OP_DATA, KIND_ZERO, '0, 1'b0);
        add_row(OP_END, 8'd2, '0, 1'b0);
        add_row(OP_WR, `ADDR_CH_ENABLE, 32'h7F, 1'b0);
        add_row(OP_PUSH, 8'h80, '0, 1'b0);           // Channel 7 off
        add_row(OP_WAIT, 8'd0, 32'd8, 1'b0);
        add_row(OP_RD, `ADDR_STATUS, 32'h0, 1'b0);
        add_row(OP_DATA, KIND_ZERO, '0, 1'b0);
        add_row(OP_WR, `ADDR_CH_ENABLE, 32'hFF, 1'b0);
        add_row(OP_END, 8'd3, '0, 1'b0);
        for (int n = 1; n <= 3; n++) begin
            add_row(OP_TRIG, 8'd0, '0, 1'b1);
            add_row(OP_DATA, KIND_TRIG, word_t'(n), 1'b0);
        end
        add_row(OP_END, 8'd4, '0, 1'b0);
        // Last grant was the trigger, so channels drain from 0
        add_row(OP_PUSH, 8'hFF, '0, 1'b1);
        add_row(OP_PUSH, 8'hFF, '0, 1'b1);
        add_row(OP_RD, `ADDR_STATUS, 32'h10, 1'b1);  // Output FIFO full
        for (int i = 0; i < 4; i++)
            add_row(OP_PUSH, 8'h01, '0, 1'b1);       // Held in channel 0
        add_row(OP_PUSH, 8'h01, '0, 1'b0);           // Dropped
        add_row(OP_TRIG, 8'd0, '0, 1'b0);            // Vetoed
        add_row(OP_RD, `ADDR_STATUS, 32'h110, 1'b0);
        for (int i = 0; i < 2 * `NUM_CHANNELS; i++)
            add_row(OP_DATA, KIND_CH, word_t'(i % `NUM_CHANNELS), 1'b0);
        for (int i = 0; i < 4; i++)
            add_row(OP_DATA, KIND_CH, 32'd0, 1'b0);
        add_row(OP_TRIG, 8'd0, '0, 1'b1);
        add_row(OP_DATA, KIND_TRIG, 32'd4, 1'b0);    // Refused edge took no number
        add_row(OP_END, 8'd5, '0, 1'b0);
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        int errs_before;
        int passed;
        int failed;
        bus_clk     = 1'b0;
        arst_n      = 1'b0;
        bus_req     = '0;
        rx_valid    = '0;
        rx_data     = '0;
        trigger_in  = 1'b0;
        errs_before = 0;
        passed      = 0;
        failed      = 0;
        build_rows();
        cycle_limit = 40 * rows.size();
        repeat (4) @(posedge bus_clk);
        #2;
        arst_n = 1'b1;
        step();

        foreach (rows[i]) begin
            case (rows[i].op)
                OP_WR:   bus_write(rows[i].a, rows[i].b[`BUS_WDATA_W-1:0]);
                OP_RD:   reg_read(rows[i].a, rows[i].b, rows[i].c);
                OP_PUSH: push_words(rows[i].a, rows[i].c);
                OP_TRIG: pulse_trigger(rows[i].c);
                OP_DATA: read_data(rows[i].a, rows[i].b);
                OP_WAIT: repeat (rows[i].b) step();
                OP_END: begin
                    if (errors == errs_before) begin
                        $display("Test %0d %s: ok", rows[i].a + 1, test_names[rows[i].a]);
                        passed++;
                    end else begin
                        $display("Test %0d %s: %0d errors", rows[i].a + 1,
                                 test_names[rows[i].a], errors - errs_before);
                        failed++;
                    end
                    errs_before = errors;
                end
                default: ;
            endcase
        end

        $display("Summary: %0d tests, %0d ok, %0d failed, %0d errors",
                 passed + failed, passed, failed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+verilog
verilog/readout_pkg.sv
verilog/readout_regs.sv
verilog/rx_channel.sv
verilog/trigger_unit.sv
verilog/rr_arbiter.sv
verilog/out_fifo.sv
verilog/readout_top.sv
tests/tb_readout.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the readout testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module tb_readout \
    -Mdir obj_dir -o tb_readout_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_readout_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF '*** TEST PASSED ***' "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
